/* tb.f */
hw/stash_pkg.sv
hw/stash_lru_store.sv
hw/stash_core.sv
hw/stash_lru.sv
hw/stash_csr_apb.sv
hw/stash_subsys.sv
verification/tb_stash.sv

/* Bender.yml */
package:
  name: stash_lru

sources:
  # Package first, then the hierarchy bottom up
  - files:
      - hw/stash_pkg.sv
      - hw/stash_lru_store.sv
      - hw/stash_core.sv
      - hw/stash_lru.sv
      - hw/stash_csr_apb.sv
      - hw/stash_subsys.sv

  # Testbench top is tb_stash
  - target: test
    files:
      - verification/tb_stash.sv

/* verification/tb_stash.sv */
`timescale 1ns/100ps

module tb_stash;

    // ----------------------------------------------------------------------
    // Constants and DUT signals
    // ----------------------------------------------------------------------
    localparam int TIMEOUT_CYCLES = 20;
    localparam int RANDOM_OPS = 400;

    logic                 clk;
    logic                 reset;
    stash_pkg::apb_req_t  apb_req;
    stash_pkg::apb_resp_t apb_resp;
    logic                 wr_valid;
    stash_pkg::wr_req_t   wr_req;
    logic                 wr_rdy;
    logic                 rd_valid;
    stash_pkg::key_t      rd_key;
    logic                 rd_rdy;
    logic                 rd_resp_valid;
    stash_pkg::rd_resp_t  rd_resp;

    // Bookkeeping
    int                   err_count;
    int                   timeout_count;
    string                cur_test;
    logic [31:0]          rng_state;
    stash_pkg::rd_resp_t  exp_q [$];
    stash_pkg::rd_resp_t  exp_resp;

    // Reference model with index 0 as the most recent entry
    stash_pkg::key_t      model_key [stash_pkg::STASH_SIZE];
    stash_pkg::value_t    model_val [stash_pkg::STASH_SIZE];
    int                   model_fill;
    int                   model_insert;
    int                   model_evict;

    stash_subsys i_stash_subsys (
        .clk           ( clk ),
        .reset         ( reset ),
        .apb_req       ( apb_req ),
        .apb_resp      ( apb_resp ),
        .wr_valid      ( wr_valid ),
        .wr_req        ( wr_req ),
        .wr_rdy        ( wr_rdy ),
        .rd_valid      ( rd_valid ),
        .rd_key        ( rd_key ),
        .rd_rdy        ( rd_rdy ),
        .rd_resp_valid ( rd_resp_valid ),
        .rd_resp       ( rd_resp )
    );

    // 100 ns period
    always #50 clk = ~clk;

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    // Applies one accepted operation and returns the expected lookup
    function automatic stash_pkg::rd_resp_t model_apply(input logic is_write,
                                                        input stash_pkg::key_t key,
                                                        input stash_pkg::value_t value);
        stash_pkg::rd_resp_t resp;
        int pos;
        resp = '0;
        pos = -1;
        for (int i = 0; i < model_fill; i++) begin
            if (model_key[i] == key) begin
                pos = i;
            end
        end
        if (pos >= 0) begin
            resp.hit = 1'b1;
            resp.value = model_val[pos];
            // Younger entries slide down one place
            for (int i = pos; i > 0; i--) begin
                model_key[i] = model_key[i-1];
                model_val[i] = model_val[i-1];
            end
            model_key[0] = key;
            model_val[0] = is_write ? value : resp.value;
        end else if (is_write) begin
            // Full stash drops the oldest entry
            if (model_fill == stash_pkg::STASH_SIZE) begin
                model_evict++;
            end else begin
                model_fill++;
            end
            model_insert++;
            for (int i = model_fill - 1; i > 0; i--) begin
                model_key[i] = model_key[i-1];
                model_val[i] = model_val[i-1];
            end
            model_key[0] = key;
            model_val[0] = value;
        end
        return resp;
    endfunction

    function automatic void model_clear();
        model_fill = 0;
        model_insert = 0;
        model_evict = 0;
    endfunction

    // Fill in 5:2, empty in bit 1, full in bit 0
    function automatic stash_pkg::apb_data_t expected_status();
        stash_pkg::apb_data_t st;
        st = '0;
        st[5:2] = 4'(model_fill);
        st[1] = (model_fill == 0);
        st[0] = (model_fill == stash_pkg::STASH_SIZE);
        return st;
    endfunction

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_resp(input string name, input stash_pkg::rd_resp_t exp,
                              input stash_pkg::rd_resp_t act);
        if (exp !== act) begin
            err_count++;
            $display("MISMATCH test=%s expected=%h actual=%h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input stash_pkg::apb_data_t exp,
                             input stash_pkg::apb_data_t act);
        if (exp !== act) begin
            err_count++;
            $display("MISMATCH test=%s expected=%h actual=%h", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            err_count++;
            $display("MISMATCH test=%s pslverr expected=%b actual=%b", name, exp, act);
        end
    endtask

    // Responses sampled mid-cycle in every valid cycle
    always @(negedge clk) begin
        if (!reset && rd_resp_valid) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("Read response arrived with no read outstanding in test %s",
                         cur_test);
            end else begin
                exp_resp = exp_q.pop_front();
                check_resp(cur_test, exp_resp, rd_resp);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Drivers
    // ----------------------------------------------------------------------
    task automatic send_write(input stash_pkg::key_t key, input stash_pkg::value_t value);
        int cycles;
        logic accepted;
        wr_valid = 1'b1;
        wr_req.key = key;
        wr_req.value = value;
        cycles = 0;
        @(negedge clk);
        while (!wr_rdy && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        accepted = wr_rdy;
        @(posedge clk);
        #10;
        wr_valid = 1'b0;
        if (accepted) begin
            void'(model_apply(1'b1, key, value));
        end else begin
            timeout_count++;
            $display("Timeout: write of key %h was never accepted in test %s", key, cur_test);
        end
    endtask

    task automatic send_read(input stash_pkg::key_t key);
        int cycles;
        logic accepted;
        rd_valid = 1'b1;
        rd_key = key;
        cycles = 0;
        @(negedge clk);
        while (!rd_rdy && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        accepted = rd_rdy;
        @(posedge clk);
        #10;
        rd_valid = 1'b0;
        // Pushed before the response shows up at the next negedge
        if (accepted) begin
            exp_q.push_back(model_apply(1'b0, key, '0));
        end else begin
            timeout_count++;
            $display("Timeout: read of key %h was never accepted in test %s", key, cur_test);
        end
    endtask

    // Setup phase, then access phase until pready
    task automatic apb_access(input logic write, input stash_pkg::apb_addr_t addr,
                              input stash_pkg::apb_data_t wdata,
                              output stash_pkg::apb_data_t rdata, output logic err);
        int cycles;
        logic done;
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = write;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(posedge clk);
        #10;
        apb_req.penable = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!apb_resp.pready && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        done = apb_resp.pready;
        rdata = apb_resp.prdata;
        err = apb_resp.pslverr;
        @(posedge clk);
        #10;
        apb_req = '0;
        if (!done) begin
            timeout_count++;
            $display("Timeout: APB access to address %h got no pready", addr);
        end
    endtask

    task automatic wait_responses();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timeout_count++;
            $display("Timeout: %0d read responses never arrived in test %s",
                     exp_q.size(), cur_test);
            exp_q.delete();
        end
    endtask

    // Status and both counters against the model
    task automatic check_model_regs();
        stash_pkg::apb_data_t rdata;
        logic err;
        apb_access(1'b0, stash_pkg::REG_STATUS, '0, rdata, err);
        check_reg({cur_test, " status"}, expected_status(), rdata);
        check_err({cur_test, " status"}, 1'b0, err);
        apb_access(1'b0, stash_pkg::REG_INSERT_CNT, '0, rdata, err);
        check_reg({cur_test, " insert count"}, 32'(stash_pkg::cnt_t'(model_insert)), rdata);
        apb_access(1'b0, stash_pkg::REG_EVICT_CNT, '0, rdata, err);
        check_reg({cur_test, " evict count"}, 32'(stash_pkg::cnt_t'(model_evict)), rdata);
    endtask

    task automatic clear_stash();
        stash_pkg::apb_data_t rdata;
        logic err;
        apb_access(1'b1, stash_pkg::REG_CTRL, 32'h1, rdata, err);
        check_err({cur_test, " ctrl write"}, 1'b0, err);
        model_clear();
        // Clear executes in this cycle
        @(negedge clk);
        if (wr_rdy || rd_rdy) begin
            err_count++;
            $display("Ready signals were high while a clear executed in test %s", cur_test);
        end
        @(posedge clk);
        #10;
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        stash_pkg::apb_data_t rdata;
        stash_pkg::apb_data_t cnt_before;
        logic err;
        logic [31:0] r;
        clk = 1'b0;
        reset = 1'b1;
        apb_req = '0;
        wr_valid = 1'b0;
        wr_req = '0;
        rd_valid = 1'b0;
        rd_key = '0;
        err_count = 0;
        timeout_count = 0;
        rng_state = 32'd7;
        cur_test = "reset";
        model_clear();
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;

        @(negedge clk);
        if (!wr_rdy || !rd_rdy) begin
            err_count++;
            $display("Ready signals were low after reset");
        end
        @(posedge clk);
        #10;
        check_model_regs();

        // Type 1, subtype 1, size on top
        cur_test = "info";
        apb_access(1'b0, stash_pkg::REG_INFO, '0, rdata, err);
        check_reg(cur_test, {16'(stash_pkg::STASH_SIZE), 8'h01, 8'h01}, rdata);
        check_err(cur_test, 1'b0, err);

        cur_test = "basic";
        for (int i = 0; i < 5; i++) begin
            send_write(8'h10 + 8'(i), 16'h1000 + 16'(i * 3));
        end
        for (int i = 0; i < 5; i++) begin
            send_read(8'h10 + 8'(i));
        end
        send_read(8'h99);
        wait_responses();
        check_model_regs();

        // Earlier keys must miss afterwards
        cur_test = "clear";
        clear_stash();
        check_model_regs();
        for (int i = 0; i < 5; i++) begin
            send_read(8'h10 + 8'(i));
        end
        wait_responses();

        // Touch three oldest keys, then push three new ones
        cur_test = "evict";
        for (int i = 0; i < 8; i++) begin
            send_write(8'h30 + 8'(i), 16'h3000 + 16'(i));
        end
        for (int i = 0; i < 3; i++) begin
            send_read(8'h30 + 8'(i));
        end
        for (int i = 0; i < 3; i++) begin
            send_write(8'h40 + 8'(i), 16'h4000 + 16'(i));
        end
        for (int i = 0; i < 8; i++) begin
            send_read(8'h30 + 8'(i));
        end
        wait_responses();
        apb_access(1'b0, stash_pkg::REG_EVICT_CNT, '0, rdata, err);
        check_reg({cur_test, " evict count"}, 32'd3, rdata);
        check_model_regs();

        // Insert count expected to stay where the model had it
        cur_test = "update";
        cnt_before = 32'(stash_pkg::cnt_t'(model_insert));
        send_write(8'h40, 16'hbeef);
        send_read(8'h40);
        wait_responses();
        apb_access(1'b0, stash_pkg::REG_INSERT_CNT, '0, rdata, err);
        check_reg({cur_test, " insert count"}, cnt_before, rdata);
        check_model_regs();

        cur_test = "registers";
        apb_access(1'b0, 8'h20, '0, rdata, err);
        check_err({cur_test, " unmapped read"}, 1'b1, err);
        apb_access(1'b1, stash_pkg::REG_STATUS, 32'hffff_ffff, rdata, err);
        check_err({cur_test, " status write"}, 1'b1, err);
        apb_access(1'b0, stash_pkg::REG_CTRL, '0, rdata, err);
        check_err({cur_test, " ctrl read"}, 1'b1, err);
        check_model_regs();

        // Twelve keys against eight slots
        cur_test = "random";
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = xorshift32();
            if (r[31]) begin
                send_write(8'h50 + 8'(r[7:0] % 12), r[23:8]);
            end else begin
                send_read(8'h50 + 8'(r[7:0] % 12));
            end
        end
        wait_responses();
        check_model_regs();

        $display("Errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_stash

/* hw/stash_subsys.sv */
`timescale 1ns/100ps

module stash_subsys (
    input  logic                 clk,
    input  logic                 reset,

    // Register access
    input  stash_pkg::apb_req_t  apb_req,
    output stash_pkg::apb_resp_t apb_resp,

    // Application write channel
    input  logic                 wr_valid,
    input  stash_pkg::wr_req_t   wr_req,
    output logic                 wr_rdy,

    // Application read channel and response
    input  logic                 rd_valid,
    input  stash_pkg::key_t      rd_key,
    output logic                 rd_rdy,
    output logic                 rd_resp_valid,
    output stash_pkg::rd_resp_t  rd_resp
);

    // ---------------------------------------------------------------------
    // Internal wiring
    // ---------------------------------------------------------------------
    logic                     clear_req;
    stash_pkg::stash_status_t status;
    stash_pkg::stash_evt_t    evt;

    // Stash datapath
    stash_lru i_stash_lru (
        .clk           ( clk ),
        .reset         ( reset ),
        .clear_req     ( clear_req ),
        .wr_valid      ( wr_valid ),
        .wr_req        ( wr_req ),
        .wr_rdy        ( wr_rdy ),
        .rd_valid      ( rd_valid ),
        .rd_key        ( rd_key ),
        .rd_rdy        ( rd_rdy ),
        .rd_resp_valid ( rd_resp_valid ),
        .rd_resp       ( rd_resp ),
        .status        ( status ),
        .evt           ( evt )
    );

    // Registers
    stash_csr_apb i_stash_csr_apb (
        .clk       ( clk ),
        .reset     ( reset ),
        .apb_req   ( apb_req ),
        .apb_resp  ( apb_resp ),
        .status    ( status ),
        .evt       ( evt ),
        .clear_req ( clear_req )
    );

endmodule : stash_subsys

/* hw/stash_csr_apb.sv */
`timescale 1ns/100ps

module stash_csr_apb (
    input  logic                     clk,
    input  logic                     reset,

    // APB slave
    input  stash_pkg::apb_req_t      apb_req,
    output stash_pkg::apb_resp_t     apb_resp,

    // Stash side
    input  stash_pkg::stash_status_t status,
    input  stash_pkg::stash_evt_t    evt,
    output logic                     clear_req
);

    // ---------------------------------------------------------------------
    // Signals
    // ---------------------------------------------------------------------
    logic access;
    logic wr_access;
    logic addr_mapped;
    logic addr_is_ctrl;
    logic access_err;

    stash_pkg::apb_data_t rd_data;

    stash_pkg::cnt_t insert_cnt_q;
    stash_pkg::cnt_t evict_cnt_q;

    // ---------------------------------------------------------------------
    // Access decode
    // ---------------------------------------------------------------------
    // Second phase of a transfer
    assign access = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;

    assign addr_is_ctrl = (apb_req.paddr == stash_pkg::REG_CTRL);

    always_comb begin
        case (apb_req.paddr)
            stash_pkg::REG_INFO,
            stash_pkg::REG_CTRL,
            stash_pkg::REG_STATUS,
            stash_pkg::REG_INSERT_CNT,
            stash_pkg::REG_EVICT_CNT: addr_mapped = 1'b1;
            default:                  addr_mapped = 1'b0;
        endcase
    end

    // CTRL is write-only, everything else read-only
    assign access_err = !addr_mapped ||
                        (apb_req.pwrite && !addr_is_ctrl) ||
                        (!apb_req.pwrite && addr_is_ctrl);

    // ---------------------------------------------------------------------
    // Read data mux
    // ---------------------------------------------------------------------
    always_comb begin
        case (apb_req.paddr)
            stash_pkg::REG_INFO:       rd_data = stash_pkg::INFO_VALUE;
            stash_pkg::REG_STATUS:     rd_data = stash_pkg::apb_data_t'(status);
            stash_pkg::REG_INSERT_CNT: rd_data = stash_pkg::apb_data_t'(insert_cnt_q);
            stash_pkg::REG_EVICT_CNT:  rd_data = stash_pkg::apb_data_t'(evict_cnt_q);
            default:                   rd_data = '0;
        endcase
    end

    // No wait states
    assign apb_resp.pready = 1'b1;
    assign apb_resp.prdata = (access && !apb_req.pwrite) ? rd_data : '0;
    assign apb_resp.pslverr = access && access_err;

    // ---------------------------------------------------------------------
    // Clear command
    // ---------------------------------------------------------------------
    // Bit 0 of CTRL, one pulse in the cycle after the access
    always_ff @(posedge clk) begin
        if (reset) begin
            clear_req <= 1'b0;
        end else begin
            clear_req <= wr_access && addr_is_ctrl && apb_req.pwdata[0];
        end
    end

    // ---------------------------------------------------------------------
    // Event counters
    // ---------------------------------------------------------------------
    // Wrap at full width
    always_ff @(posedge clk) begin
        if (reset || clear_req) begin
            insert_cnt_q <= '0;
            evict_cnt_q <= '0;
        end else begin
            insert_cnt_q <= insert_cnt_q + stash_pkg::cnt_t'(evt.insert);
            evict_cnt_q <= evict_cnt_q + stash_pkg::cnt_t'(evt.evict);
        end
    end

endmodule : stash_csr_apb

/* hw/stash_lru.sv */
`timescale 1ns/100ps

module stash_lru (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clear_req,

    // Write channel
    input  logic                     wr_valid,
    input  stash_pkg::wr_req_t       wr_req,
    output logic                     wr_rdy,

    // Read channel
    input  logic                     rd_valid,
    input  stash_pkg::key_t          rd_key,
    output logic                     rd_rdy,
    output logic                     rd_resp_valid,
    output stash_pkg::rd_resp_t      rd_resp,

    // Status and events
    output stash_pkg::stash_status_t status,
    output stash_pkg::stash_evt_t    evt
);

    // ---------------------------------------------------------------------
    // Signals
    // ---------------------------------------------------------------------
    stash_pkg::store_op_e  op;
    stash_pkg::key_t       key;
    stash_pkg::value_t     value;
    stash_pkg::rd_resp_t   lookup;
    stash_pkg::stash_evt_t store_evt;

    stash_pkg::fill_t fill_q;

    // ---------------------------------------------------------------------
    // Request arbitration and response
    // ---------------------------------------------------------------------
    stash_core i_stash_core (
        .clk           ( clk ),
        .reset         ( reset ),
        .clear_req     ( clear_req ),
        .wr_valid      ( wr_valid ),
        .wr_req        ( wr_req ),
        .wr_rdy        ( wr_rdy ),
        .rd_valid      ( rd_valid ),
        .rd_key        ( rd_key ),
        .rd_rdy        ( rd_rdy ),
        .rd_resp_valid ( rd_resp_valid ),
        .rd_resp       ( rd_resp ),
        .op            ( op ),
        .key           ( key ),
        .value         ( value ),
        .lookup        ( lookup )
    );

    // ---------------------------------------------------------------------
    // LRU entry store
    // ---------------------------------------------------------------------
    stash_lru_store i_stash_lru_store (
        .clk    ( clk ),
        .reset  ( reset ),
        .op     ( op ),
        .key    ( key ),
        .value  ( value ),
        .lookup ( lookup ),
        .evt    ( store_evt )
    );

    // ---------------------------------------------------------------------
    // Fill count
    // ---------------------------------------------------------------------
    // Grows only when an insert finds a free slot
    always_ff @(posedge clk) begin
        if (reset || clear_req) begin
            fill_q <= '0;
        end else if (store_evt.insert && !store_evt.evict) begin
            fill_q <= fill_q + 1'b1;
        end
    end

    assign status.fill = fill_q;
    assign status.empty = (fill_q == '0);
    assign status.full = (fill_q == stash_pkg::fill_t'(stash_pkg::STASH_SIZE));

    // Event pulses one cycle behind the store edge
    always_ff @(posedge clk) begin
        if (reset) begin
            evt <= '0;
        end else begin
            evt <= store_evt;
        end
    end

endmodule : stash_lru

/* hw/stash_core.sv */
`timescale 1ns/100ps

module stash_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear_req,

    // Write channel
    input  logic                 wr_valid,
    input  stash_pkg::wr_req_t   wr_req,
    output logic                 wr_rdy,

    // Read channel
    input  logic                 rd_valid,
    input  stash_pkg::key_t      rd_key,
    output logic                 rd_rdy,
    output logic                 rd_resp_valid,
    output stash_pkg::rd_resp_t  rd_resp,

    // Store side
    output stash_pkg::store_op_e op,
    output stash_pkg::key_t      key,
    output stash_pkg::value_t    value,
    input  stash_pkg::rd_resp_t  lookup
);

    // ---------------------------------------------------------------------
    // Signals
    // ---------------------------------------------------------------------
    logic rd_accept;

    // ---------------------------------------------------------------------
    // Operation select
    // ---------------------------------------------------------------------
    // Clear first, then write, then read
    always_comb begin
        if (clear_req) begin
            op = stash_pkg::OP_CLEAR;
        end else if (wr_valid) begin
            op = stash_pkg::OP_WRITE;
        end else if (rd_valid) begin
            op = stash_pkg::OP_READ;
        end else begin
            op = stash_pkg::OP_NONE;
        end
    end

    // Ready follows the same priority
    assign wr_rdy = !clear_req;
    // A pending write takes the store this cycle
    assign rd_rdy = !clear_req && !wr_valid;

    assign rd_accept = rd_valid && rd_rdy;

    // ---------------------------------------------------------------------
    // Store request steering
    // ---------------------------------------------------------------------
    // Write key when writing, read key otherwise
    assign key = (op == stash_pkg::OP_WRITE) ? wr_req.key : rd_key;
    // Value only matters for writes
    assign value = wr_req.value;

    // ---------------------------------------------------------------------
    // Read response
    // ---------------------------------------------------------------------
    // Response valid one cycle after the accepting edge
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_resp_valid <= 1'b0;
        end else begin
            rd_resp_valid <= rd_accept;
        end
    end

    // Lookup sampled before the store reorders
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_resp <= lookup;
        end
    end

endmodule : stash_core

/* hw/stash_lru_store.sv */
`timescale 1ns/100ps

module stash_lru_store (
    input  logic                 clk,
    input  logic                 reset,
    input  stash_pkg::store_op_e op,
    input  stash_pkg::key_t      key,
    input  stash_pkg::value_t    value,
    output stash_pkg::rd_resp_t  lookup,
    output stash_pkg::stash_evt_t evt
);

    // ---------------------------------------------------------------------
    // Entry array, position 0 is the most recently used
    // ---------------------------------------------------------------------
    logic [stash_pkg::STASH_SIZE-1:0] valid_q;
    stash_pkg::key_t                  key_q [stash_pkg::STASH_SIZE];
    stash_pkg::value_t                value_q [stash_pkg::STASH_SIZE];

    // One bit per position that matches the key
    logic [stash_pkg::STASH_SIZE-1:0] match;
    logic                             hit;
    stash_pkg::value_t                hit_value;

    // Bit 0 loads the head, higher bits take from the next younger slot
    logic [stash_pkg::STASH_SIZE-1:0] shift_en;
    logic                             is_write;
    logic                             write_miss;
    logic                             move;

    // ---------------------------------------------------------------------
    // Parallel key compare
    // ---------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < stash_pkg::STASH_SIZE; i++) begin
            match[i] = valid_q[i] && (key_q[i] == key);
        end
    end

    assign hit = |match;

    // Keys are unique, so at most one position contributes
    always_comb begin
        hit_value = '0;
        for (int i = 0; i < stash_pkg::STASH_SIZE; i++) begin
            if (match[i]) begin
                hit_value = hit_value | value_q[i];
            end
        end
    end

    // Value stays zero on a miss
    assign lookup.hit = hit;
    assign lookup.value = hit_value;

    // ---------------------------------------------------------------------
    // Move control
    // ---------------------------------------------------------------------
    assign is_write = (op == stash_pkg::OP_WRITE);
    assign write_miss = is_write && !hit;
    // Any write, or a read that hits, updates the order
    assign move = is_write || ((op == stash_pkg::OP_READ) && hit);

    always_comb begin
        logic at_or_above_hit;
        at_or_above_hit = 1'b0;
        shift_en[0] = move;
        // Walk down from the oldest slot
        for (int i = stash_pkg::STASH_SIZE - 1; i > 0; i--) begin
            at_or_above_hit = at_or_above_hit | match[i];
            shift_en[i] = move && (write_miss || at_or_above_hit);
        end
    end

    // Insert on every write miss, evict when the oldest slot was in use
    assign evt.insert = write_miss;
    assign evt.evict = write_miss && valid_q[stash_pkg::STASH_SIZE-1];

    // ---------------------------------------------------------------------
    // Valid bits
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || (op == stash_pkg::OP_CLEAR)) begin
            valid_q <= '0;
        end else begin
            for (int i = 1; i < stash_pkg::STASH_SIZE; i++) begin
                if (shift_en[i]) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
            if (shift_en[0]) begin
                valid_q[0] <= 1'b1;
            end
        end
    end

    // ---------------------------------------------------------------------
    // Keys and values
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int i = 1; i < stash_pkg::STASH_SIZE; i++) begin
            if (shift_en[i]) begin
                key_q[i] <= key_q[i-1];
                value_q[i] <= value_q[i-1];
            end
        end
        if (shift_en[0]) begin
            // Same key on a hit, new key on a miss
            key_q[0] <= key;
            // Read hit keeps the stored value
            value_q[0] <= is_write ? value : hit_value;
        end
    end

endmodule : stash_lru_store

/* hw/stash_pkg.sv */
package stash_pkg;

    // ---------------------------------------------------------------------
    // Sizes and widths
    // ---------------------------------------------------------------------
    localparam int STASH_SIZE = 8;
    localparam int KEY_WID = 8;
    localparam int VALUE_WID = 16;
    // Holds 0 up to STASH_SIZE
    localparam int FILL_WID = $clog2(STASH_SIZE + 1);
    localparam int CNT_WID = 16;
    localparam int APB_ADDR_WID = 8;
    localparam int APB_DATA_WID = 32;

    // ---------------------------------------------------------------------
    // Vector types
    // ---------------------------------------------------------------------
    typedef logic [KEY_WID-1:0] key_t;
    typedef logic [VALUE_WID-1:0] value_t;
    typedef logic [FILL_WID-1:0] fill_t;
    typedef logic [CNT_WID-1:0] cnt_t;
    typedef logic [APB_ADDR_WID-1:0] apb_addr_t;
    typedef logic [APB_DATA_WID-1:0] apb_data_t;

    // ---------------------------------------------------------------------
    // Register map
    // ---------------------------------------------------------------------
    localparam apb_addr_t REG_INFO = 8'h00;
    localparam apb_addr_t REG_CTRL = 8'h04;
    localparam apb_addr_t REG_STATUS = 8'h08;
    localparam apb_addr_t REG_INSERT_CNT = 8'h0C;
    localparam apb_addr_t REG_EVICT_CNT = 8'h10;

    // Size in 31:16, LRU subtype in 15:8, stash type in 7:0
    localparam apb_data_t INFO_VALUE = {16'(STASH_SIZE), 8'd1, 8'd1};

    // ---------------------------------------------------------------------
    // Structs
    // ---------------------------------------------------------------------
    typedef struct packed {
        key_t   key;
        value_t value;
    } wr_req_t;

    // Value reads as zero on a miss
    typedef struct packed {
        logic   hit;
        value_t value;
    } rd_resp_t;

    typedef struct packed {
        logic insert;
        logic evict;
    } stash_evt_t;

    // Read back as is: full in bit 0, empty in bit 1, fill above
    typedef struct packed {
        fill_t fill;
        logic  empty;
        logic  full;
    } stash_status_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_resp_t;

    // Per-cycle operation from core to store
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_CLEAR = 2'd1,
        OP_WRITE = 2'd2,
        OP_READ  = 2'd3
    } store_op_e;

endpackage : stash_pkg
